// File: Bender.yml
package:
  name: fetch_front

sources:
  - logic/fetch_pkg.sv
  - logic/mem_bus_if.sv
  - logic/icache.sv
  - logic/mem_arbiter.sv
  - logic/fetch_stage.sv
  - logic/dispatch_reg.sv
  - logic/fetch_front.sv
  - target: simulation
    files:
      - sim/fetch_properties.sv
      - sim/fetch_tb.sv

// File: fetch_front.f
logic/fetch_pkg.sv
logic/mem_bus_if.sv
logic/icache.sv
logic/mem_arbiter.sv
logic/fetch_stage.sv
logic/dispatch_reg.sv
logic/fetch_front.sv
sim/fetch_properties.sv
sim/fetch_tb.sv

// File: logic/dispatch_reg.sv
module dispatch_reg (
	input logic clock,
	input logic reset,
	input logic squash,
	input logic rob_full,
	input logic rs_full,
	input logic [fetch_pkg::inst_width-1:0] inst,
	input logic [fetch_pkg::xlen-1:0] npc,
	input logic inst_valid,
	output logic hold,
	output logic [fetch_pkg::xlen-1:0] id_ex_npc,
	output logic [fetch_pkg::inst_width-1:0] id_ex_ir,
	output logic id_ex_valid_inst
);

	// back-pressure from the downstream structures
	assign hold = rob_full || rs_full;

	////////////////////////////////////////
	// pipeline register
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset || squash) begin
			// squash overrides hold
			id_ex_npc <= '0;
			id_ex_ir <= '0;
			id_ex_valid_inst <= 1'b0;
		end else if (!hold) begin
			// bubbles load too, with valid low
			id_ex_npc <= npc;
			id_ex_ir <= inst;
			id_ex_valid_inst <= inst_valid;
		end
	end

endmodule

// File: logic/fetch_front.sv
module fetch_front (
	input logic clock,
	input logic reset,
	input logic [fetch_pkg::tag_width-1:0] mem2proc_response,
	input logic [fetch_pkg::mem_width-1:0] mem2proc_data,
	input logic [fetch_pkg::tag_width-1:0] mem2proc_tag,
	input logic [fetch_pkg::cmd_width-1:0] dmem_command,
	input logic [fetch_pkg::xlen-1:0] dmem_addr,
	input logic [fetch_pkg::mem_width-1:0] dmem_data,
	input logic rob_full,
	input logic rs_full,
	input logic squash,
	input logic [fetch_pkg::xlen-1:0] squash_pc,
	output logic [fetch_pkg::cmd_width-1:0] proc2mem_command,
	output logic [fetch_pkg::xlen-1:0] proc2mem_addr,
	output logic [fetch_pkg::mem_width-1:0] proc2mem_data,
	output logic [fetch_pkg::tag_width-1:0] dmem_tag,
	output logic dmem_reply_valid,
	output logic [fetch_pkg::xlen-1:0] id_ex_npc,
	output logic [fetch_pkg::inst_width-1:0] id_ex_ir,
	output logic id_ex_valid_inst
);

	// fetch path wires
	logic [fetch_pkg::xlen-1:0] fetch_addr;
	fetch_pkg::mem_word_t line;
	logic line_valid;
	logic [fetch_pkg::inst_width-1:0] inst;
	logic [fetch_pkg::xlen-1:0] npc;
	logic inst_valid;
	logic hold;

	// icache to arbiter
	mem_bus_if icache_bus ();

	icache icache_0 (
		.clock(clock),
		.reset(reset),
		.squash(squash),
		.fetch_addr(fetch_addr),
		.mem(icache_bus.requester),
		.line(line),
		.line_valid(line_valid)
	);

	mem_arbiter mem_arbiter_0 (
		.clock(clock),
		.reset(reset),
		.mem(icache_bus.server),
		.dmem_command(dmem_command),
		.dmem_addr(dmem_addr),
		.dmem_data(dmem_data),
		.mem2proc_response(mem2proc_response),
		.mem2proc_data(mem2proc_data),
		.mem2proc_tag(mem2proc_tag),
		.proc2mem_command(proc2mem_command),
		.proc2mem_addr(proc2mem_addr),
		.proc2mem_data(proc2mem_data),
		.dmem_tag(dmem_tag),
		.dmem_reply_valid(dmem_reply_valid)
	);

	fetch_stage fetch_stage_0 (
		.clock(clock),
		.reset(reset),
		.squash(squash),
		.squash_pc(squash_pc),
		.hold(hold),
		.line(line),
		.line_valid(line_valid),
		.fetch_addr(fetch_addr),
		.inst(inst),
		.npc(npc),
		.inst_valid(inst_valid)
	);

	dispatch_reg dispatch_reg_0 (
		.clock(clock),
		.reset(reset),
		.squash(squash),
		.rob_full(rob_full),
		.rs_full(rs_full),
		.inst(inst),
		.npc(npc),
		.inst_valid(inst_valid),
		.hold(hold),
		.id_ex_npc(id_ex_npc),
		.id_ex_ir(id_ex_ir),
		.id_ex_valid_inst(id_ex_valid_inst)
	);

endmodule

// File: logic/fetch_pkg.sv
package fetch_pkg;

	////////////////////////////////////////
	// widths
	////////////////////////////////////////

	// address and pc width
	localparam int xlen = 32;
	// one instruction
	localparam int inst_width = 32;
	// one memory word, two instructions
	localparam int mem_width = 64;
	// memory tag, zero means no tag
	localparam int tag_width = 4;
	localparam int cmd_width = 2;

	// memory bus commands
	localparam logic [cmd_width-1:0] bus_none = 2'd0;
	localparam logic [cmd_width-1:0] bus_load = 2'd1;
	localparam logic [cmd_width-1:0] bus_store = 2'd2;

	////////////////////////////////////////
	// icache geometry
	////////////////////////////////////////

	localparam int cache_lines = 32;
	// index comes from address bits 7..3
	localparam int index_width = 5;
	// byte offset inside one memory word
	localparam int offset_width = 3;
	// whatever is left above the index
	localparam int line_tag_width = xlen - index_width - offset_width;

	// icache miss fsm
	localparam int ic_state_width = 2;
	localparam logic [ic_state_width-1:0] ic_start = 2'd0;
	localparam logic [ic_state_width-1:0] ic_lookup = 2'd1;
	localparam logic [ic_state_width-1:0] ic_wait = 2'd2;

	// one memory word, seen as a doubleword on fill
	// or as an instruction pair on fetch, pc bit 2 picks the element
	typedef union packed {
		logic [mem_width-1:0] dword;
		logic [1:0][inst_width-1:0] inst;
	} mem_word_t;

endpackage

// File: logic/fetch_stage.sv
module fetch_stage (
	input logic clock,
	input logic reset,
	input logic squash,
	input logic [fetch_pkg::xlen-1:0] squash_pc,
	input logic hold,
	input fetch_pkg::mem_word_t line,
	input logic line_valid,
	output logic [fetch_pkg::xlen-1:0] fetch_addr,
	output logic [fetch_pkg::inst_width-1:0] inst,
	output logic [fetch_pkg::xlen-1:0] npc,
	output logic inst_valid
);

	logic [fetch_pkg::xlen-1:0] pc;
	logic advance;

	// step only when the cache has the word and dispatch takes it
	assign advance = line_valid && !hold;

	////////////////////////////////////////
	// pc register
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			pc <= '0;
		end else if (squash) begin
			// redirect beats a stall
			pc <= squash_pc;
		end else if (advance) begin
			pc <= pc + 32'd4;
		end
	end

	// the cache is looked up with the current pc
	assign fetch_addr = pc;

	// pc bit 2 picks the half of the doubleword
	assign inst = line.inst[pc[2]];

	// next pc travels with the instruction
	assign npc = pc + 32'd4;
	assign inst_valid = line_valid;

endmodule

// File: logic/icache.sv
module icache (
	input logic clock,
	input logic reset,
	input logic squash,
	input logic [fetch_pkg::xlen-1:0] fetch_addr,
	mem_bus_if.requester mem,
	output fetch_pkg::mem_word_t line,
	output logic line_valid
);

	////////////////////////////////////////
	// storage
	////////////////////////////////////////

	fetch_pkg::mem_word_t lines [fetch_pkg::cache_lines];
	logic [fetch_pkg::line_tag_width-1:0] tags [fetch_pkg::cache_lines];
	logic [fetch_pkg::cache_lines-1:0] valid;

	// miss tracking
	logic [fetch_pkg::ic_state_width-1:0] state;
	logic [fetch_pkg::tag_width-1:0] wait_tag;
	logic [fetch_pkg::index_width-1:0] fill_index;
	logic [fetch_pkg::line_tag_width-1:0] fill_tag;

	// address split
	logic [fetch_pkg::index_width-1:0] index;
	logic [fetch_pkg::line_tag_width-1:0] addr_tag;

	logic miss_req;
	logic accepted;
	logic reply_hit;

	assign index = fetch_addr[fetch_pkg::offset_width +: fetch_pkg::index_width];
	assign addr_tag = fetch_addr[fetch_pkg::xlen-1 -: fetch_pkg::line_tag_width];

	// hit path is purely combinational
	assign line = lines[index];
	assign line_valid = valid[index] && (tags[index] == addr_tag);

	// no new request while a squash redirects the pc
	assign miss_req = (state == fetch_pkg::ic_lookup) && !line_valid && !squash;
	assign accepted = miss_req && (mem.response != '0);
	// wait_tag is never zero while waiting
	assign reply_hit = (state == fetch_pkg::ic_wait) && (mem.tag == wait_tag);

	////////////////////////////////////////
	// bus request
	////////////////////////////////////////

	assign mem.command = miss_req ? fetch_pkg::bus_load : fetch_pkg::bus_none;
	// whole doubleword, offset bits dropped
	assign mem.addr = {fetch_addr[fetch_pkg::xlen-1:fetch_pkg::offset_width],
		{fetch_pkg::offset_width{1'b0}}};
	assign mem.data = '0;

	// miss fsm
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= fetch_pkg::ic_start;
			valid <= '0;
			wait_tag <= '0;
		end else begin
			case (state)
				// one quiet cycle after reset
				fetch_pkg::ic_start: begin
					state <= fetch_pkg::ic_lookup;
				end
				fetch_pkg::ic_lookup: begin
					// zero response means retry next cycle
					if (accepted) begin
						wait_tag <= mem.response;
						state <= fetch_pkg::ic_wait;
					end
				end
				fetch_pkg::ic_wait: begin
					if (squash) begin
						// abandon, the late reply is ignored
						wait_tag <= '0;
						state <= fetch_pkg::ic_lookup;
					end else if (reply_hit) begin
						valid[fill_index] <= 1'b1;
						wait_tag <= '0;
						state <= fetch_pkg::ic_lookup;
					end
				end
				default: begin
					state <= fetch_pkg::ic_start;
				end
			endcase
		end
	end

	// line data and tags
	always_ff @(posedge clock) begin
		if (accepted) begin
			fill_index <= index;
			fill_tag <= addr_tag;
		end
		if (reply_hit && !squash) begin
			lines[fill_index].dword <= mem.rdata;
			tags[fill_index] <= fill_tag;
		end
	end

endmodule

// File: logic/mem_arbiter.sv
module mem_arbiter (
	input logic clock,
	input logic reset,
	mem_bus_if.server mem,
	input logic [fetch_pkg::cmd_width-1:0] dmem_command,
	input logic [fetch_pkg::xlen-1:0] dmem_addr,
	input logic [fetch_pkg::mem_width-1:0] dmem_data,
	input logic [fetch_pkg::tag_width-1:0] mem2proc_response,
	input logic [fetch_pkg::mem_width-1:0] mem2proc_data,
	input logic [fetch_pkg::tag_width-1:0] mem2proc_tag,
	output logic [fetch_pkg::cmd_width-1:0] proc2mem_command,
	output logic [fetch_pkg::xlen-1:0] proc2mem_addr,
	output logic [fetch_pkg::mem_width-1:0] proc2mem_data,
	output logic [fetch_pkg::tag_width-1:0] dmem_tag,
	output logic dmem_reply_valid
);

	// one bit per nonzero tag, bit n is tag n+1
	logic [(1 << fetch_pkg::tag_width)-2:0] owned;
	logic data_grant;

	// data side wins whenever it asks
	assign data_grant = (dmem_command != fetch_pkg::bus_none);

	////////////////////////////////////////
	// request mux
	////////////////////////////////////////

	assign proc2mem_command = data_grant ? dmem_command : mem.command;
	assign proc2mem_addr = data_grant ? dmem_addr : mem.addr;
	assign proc2mem_data = data_grant ? dmem_data : mem.data;

	// acceptance goes only to the granted side
	assign dmem_tag = data_grant ? mem2proc_response : '0;
	assign mem.response = data_grant ? '0 : mem2proc_response;

	// reply routing by ownership
	assign dmem_reply_valid = (mem2proc_tag != '0) && owned[mem2proc_tag - 1'b1];
	assign mem.tag = dmem_reply_valid ? '0 : mem2proc_tag;
	assign mem.rdata = mem2proc_data;

	// clear on reply first, a fresh acceptance of the same tag wins
	always_ff @(posedge clock) begin
		if (reset) begin
			owned <= '0;
		end else begin
			if (dmem_reply_valid)
				owned[mem2proc_tag - 1'b1] <= 1'b0;
			if (dmem_tag != '0)
				owned[dmem_tag - 1'b1] <= 1'b1;
		end
	end

endmodule

// File: logic/mem_bus_if.sv
interface mem_bus_if;

	// request side
	logic [fetch_pkg::cmd_width-1:0] command;
	logic [fetch_pkg::xlen-1:0] addr;
	// store data, always zero from the icache
	logic [fetch_pkg::mem_width-1:0] data;

	// acceptance tag, same cycle as the command
	logic [fetch_pkg::tag_width-1:0] response;
	// reply tag pulse, only for tags the data side does not own
	logic [fetch_pkg::tag_width-1:0] tag;
	// reply line, valid while tag matches
	logic [fetch_pkg::mem_width-1:0] rdata;

	// icache side
	modport requester (
		output command, addr, data,
		input response, tag, rdata
	);

	// arbiter side
	modport server (
		input command, addr, data,
		output response, tag, rdata
	);

endinterface

// File: sim/fetch_properties.sv
module fetch_properties (
	input logic clock,
	input logic reset,
	input logic [fetch_pkg::tag_width-1:0] mem2proc_response,
	input logic [fetch_pkg::tag_width-1:0] mem2proc_tag,
	input logic [fetch_pkg::cmd_width-1:0] dmem_command,
	input logic [fetch_pkg::xlen-1:0] dmem_addr,
	input logic [fetch_pkg::mem_width-1:0] dmem_data,
	input logic rob_full,
	input logic rs_full,
	input logic squash,
	input logic [fetch_pkg::xlen-1:0] squash_pc,
	input logic [fetch_pkg::cmd_width-1:0] proc2mem_command,
	input logic [fetch_pkg::xlen-1:0] proc2mem_addr,
	input logic [fetch_pkg::mem_width-1:0] proc2mem_data,
	input logic [fetch_pkg::tag_width-1:0] dmem_tag,
	input logic dmem_reply_valid,
	input logic [fetch_pkg::xlen-1:0] id_ex_npc,
	input logic [fetch_pkg::inst_width-1:0] id_ex_ir,
	input logic id_ex_valid_inst
);
	timeunit 1ns;
	timeprecision 100ps;

	int failures = 0;
	// npc the next fresh dispatch must carry
	logic [fetch_pkg::xlen-1:0] expect_npc;
	// data side tags accepted but not yet replied
	logic [(1 << fetch_pkg::tag_width)-1:0] issued;
	logic data_req;
	logic stalled;

	assign data_req = dmem_command != fetch_pkg::bus_none;
	assign stalled = rob_full || rs_full;

	function void flag_mismatch(input string name, input logic [63:0] got,
		input logic [63:0] want);
		failures++;
		$error("CHECK FAILED t=%0t %s got %h expected %h", $time, name, got, want);
	endfunction

	// reference model of the fetch order and tag ownership
	always_ff @(posedge clock) begin
		if (reset) begin
			expect_npc <= 32'd4;
			issued <= '0;
		end else begin
			if (squash)
				expect_npc <= squash_pc + 32'd4;
			else if (id_ex_valid_inst)
				expect_npc <= id_ex_npc + 32'd4;
			// any reply retires its tag
			if (mem2proc_tag != '0)
				issued[mem2proc_tag] <= 1'b0;
			if (dmem_tag != '0)
				issued[dmem_tag] <= 1'b1;
		end
	end

	////////////////////////////////////////
	// reset
	////////////////////////////////////////

	assert property (@(posedge clock) reset |=> proc2mem_command == fetch_pkg::bus_none)
		else flag_mismatch("proc2mem_command", $sampled(proc2mem_command), fetch_pkg::bus_none);
	assert property (@(posedge clock) reset |=> !id_ex_valid_inst)
		else flag_mismatch("id_ex_valid_inst", $sampled(id_ex_valid_inst), 0);
	// first cycle after release
	assert property (@(posedge clock) reset ##1 !reset |=> !id_ex_valid_inst)
		else flag_mismatch("id_ex_valid_inst", $sampled(id_ex_valid_inst), 0);

	////////////////////////////////////////
	// dispatch contents and order
	////////////////////////////////////////

	assert property (@(posedge clock) disable iff (reset)
		id_ex_valid_inst |-> id_ex_ir == ((id_ex_npc - 32'd4) ^ 32'hc0de0000))
		else flag_mismatch("id_ex_ir", $sampled(id_ex_ir),
			($sampled(id_ex_npc) - 32'd4) ^ 32'hc0de0000);
	// only a freshly loaded dispatch is checked
	assert property (@(posedge clock) disable iff (reset)
		id_ex_valid_inst && $past(!stalled && !squash) |-> id_ex_npc == expect_npc)
		else flag_mismatch("id_ex_npc", $sampled(id_ex_npc), $sampled(expect_npc));

	// stall holds everything
	assert property (@(posedge clock) disable iff (reset)
		stalled && !squash |=> $stable(id_ex_npc))
		else flag_mismatch("id_ex_npc", $sampled(id_ex_npc), $past(id_ex_npc));
	assert property (@(posedge clock) disable iff (reset)
		stalled && !squash |=> $stable(id_ex_ir))
		else flag_mismatch("id_ex_ir", $sampled(id_ex_ir), $past(id_ex_ir));
	assert property (@(posedge clock) disable iff (reset)
		stalled && !squash |=> $stable(id_ex_valid_inst))
		else flag_mismatch("id_ex_valid_inst", $sampled(id_ex_valid_inst),
			$past(id_ex_valid_inst));

	////////////////////////////////////////
	// memory port
	////////////////////////////////////////

	assert property (@(posedge clock) data_req |-> proc2mem_command == dmem_command)
		else flag_mismatch("proc2mem_command", $sampled(proc2mem_command),
			$sampled(dmem_command));
	assert property (@(posedge clock) data_req |-> proc2mem_addr == dmem_addr)
		else flag_mismatch("proc2mem_addr", $sampled(proc2mem_addr), $sampled(dmem_addr));
	assert property (@(posedge clock) data_req |-> proc2mem_data == dmem_data)
		else flag_mismatch("proc2mem_data", $sampled(proc2mem_data), $sampled(dmem_data));
	assert property (@(posedge clock) data_req |-> dmem_tag == mem2proc_response)
		else flag_mismatch("dmem_tag", $sampled(dmem_tag), $sampled(mem2proc_response));
	// data replies flagged, fill replies never
	assert property (@(posedge clock) disable iff (reset)
		mem2proc_tag != '0 |-> dmem_reply_valid == issued[mem2proc_tag])
		else flag_mismatch("dmem_reply_valid", $sampled(dmem_reply_valid),
			$sampled(issued[mem2proc_tag]));

endmodule

bind fetch_front fetch_properties props (.*);

// File: sim/fetch_tb.sv
module fetch_tb;
	timeunit 1ns;
	timeprecision 100ps;

	logic clock;
	logic reset;
	logic [fetch_pkg::tag_width-1:0] mem2proc_response;
	logic [fetch_pkg::mem_width-1:0] mem2proc_data;
	logic [fetch_pkg::tag_width-1:0] mem2proc_tag;
	logic [fetch_pkg::cmd_width-1:0] dmem_command;
	logic [fetch_pkg::xlen-1:0] dmem_addr;
	logic [fetch_pkg::mem_width-1:0] dmem_data;
	logic rob_full;
	logic rs_full;
	logic squash;
	logic [fetch_pkg::xlen-1:0] squash_pc;
	logic [fetch_pkg::cmd_width-1:0] proc2mem_command;
	logic [fetch_pkg::xlen-1:0] proc2mem_addr;
	logic [fetch_pkg::mem_width-1:0] proc2mem_data;
	logic [fetch_pkg::tag_width-1:0] dmem_tag;
	logic dmem_reply_valid;
	logic [fetch_pkg::xlen-1:0] id_ex_npc;
	logic [fetch_pkg::inst_width-1:0] id_ex_ir;
	logic id_ex_valid_inst;

	// memory model with a three stage reply pipe
	logic [fetch_pkg::tag_width-1:0] next_tag;
	logic [fetch_pkg::tag_width-1:0] tag_pipe [3];
	logic [fetch_pkg::xlen-1:0] addr_pipe [3];
	logic [31:0] lfsr;
	int phases;
	bit timed_out;

	fetch_front dut (.*);

	always #2 clock = ~clock;

	function automatic logic [31:0] word_at(input logic [31:0] addr);
		return addr ^ 32'hc0de0000;
	endfunction

	// galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < n; i++) begin
			value = {value[30:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
		return value;
	endfunction

	////////////////////////////////////////
	// memory model
	////////////////////////////////////////

	// every request accepted in its own cycle
	assign mem2proc_response = (!reset && proc2mem_command != fetch_pkg::bus_none) ?
		next_tag : '0;

	always @(posedge clock) begin
		for (int i = 2; i > 0; i--) begin
			tag_pipe[i] = tag_pipe[i-1];
			addr_pipe[i] = addr_pipe[i-1];
		end
		tag_pipe[0] = mem2proc_response;
		addr_pipe[0] = proc2mem_addr;
		#1;
		// tags run 1..15 and skip zero
		if (tag_pipe[0] != '0)
			next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
		mem2proc_tag = tag_pipe[2];
		mem2proc_data = {word_at(addr_pipe[2] + 32'd4), word_at(addr_pipe[2])};
	end

	task automatic wait_for_dispatch(input string name);
		int waited;
		waited = 0;
		while (!id_ex_valid_inst && waited < 200) begin
			@(posedge clock);
			#1;
			waited++;
		end
		if (!id_ex_valid_inst) begin
			$display("%s: no valid dispatch within %0d cycles", name, waited);
			timed_out = 1'b1;
		end
	endtask

	// random back-pressure and data traffic with one squash per phase
	task automatic run_phase(input string name, input bit stall, input bit data,
		input int cycles);
		int squash_cycle;
		int valid_cycles;
		squash_cycle = 8 + take_bits(5);
		valid_cycles = 0;
		for (int c = 0; c < cycles; c++) begin
			@(posedge clock);
			#1;
			if (id_ex_valid_inst)
				valid_cycles++;
			rob_full = stall && take_bits(2) == 0;
			rs_full = stall && take_bits(2) == 0;
			squash = (c == squash_cycle);
			if (squash)
				squash_pc = take_bits(8) << 2;
			if (data && take_bits(2) == 0) begin
				dmem_command = take_bits(1) ? fetch_pkg::bus_store : fetch_pkg::bus_load;
				dmem_addr = take_bits(8) << 3;
				dmem_data = {take_bits(32), take_bits(32)};
			end else begin
				dmem_command = fetch_pkg::bus_none;
			end
		end
		@(posedge clock);
		#1;
		rob_full = 1'b0;
		rs_full = 1'b0;
		squash = 1'b0;
		dmem_command = fetch_pkg::bus_none;
		wait_for_dispatch(name);
		phases++;
		$display("phase %s done: %0d valid cycles, %0d failures so far",
			name, valid_cycles, dut.props.failures);
	endtask

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		dmem_command = fetch_pkg::bus_none;
		dmem_addr = '0;
		dmem_data = '0;
		rob_full = 1'b0;
		rs_full = 1'b0;
		squash = 1'b0;
		squash_pc = '0;
		next_tag = 4'd1;
		mem2proc_tag = '0;
		mem2proc_data = '0;
		for (int i = 0; i < 3; i++) begin
			tag_pipe[i] = '0;
			addr_pipe[i] = '0;
		end
		lfsr = 32'h5d0a2061;
		phases = 0;
		timed_out = 1'b0;
		repeat (3) @(posedge clock);
		#1;
		reset = 1'b0;
		wait_for_dispatch("reset");
		phases++;
		$display("phase reset done: first dispatch npc %h", id_ex_npc);
		run_phase("stream", 1'b0, 1'b0, 60);
		run_phase("stall", 1'b1, 1'b0, 80);
		run_phase("data", 1'b0, 1'b1, 80);
		run_phase("mixed", 1'b1, 1'b1, 120);
		$display("%0d phases run, %0d checks failed, %0d timeouts", phases,
			dut.props.failures, timed_out);
		if (dut.props.failures == 0 && !timed_out) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule
